// File: list.f
verilog/mem_pkg.sv
verilog/store_merge.sv
verilog/load_extend.sv
verilog/word_ram.sv
verilog/mem_sequencer.sv
verilog/data_mem_unit.sv
tests/tb_data_mem_unit.sv

// File: tests/golden_vectors.txt
# op (0 load, 1 store)  funct3  byte address  write data  expected rdata  expected fault
# all columns in hex; rdata is ignored for stores and faults
1 2 000 12345678 00000000 0
0 2 000 00000000 12345678 0
1 2 004 deadbeef 00000000 0
0 2 004 00000000 deadbeef 0
1 2 010 11223344 00000000 0
1 0 010 000000aa 00000000 0
0 2 010 00000000 112233aa 0
1 0 011 000000bb 00000000 0
0 2 010 00000000 1122bbaa 0
1 0 012 ffffffcc 00000000 0
0 2 010 00000000 11ccbbaa 0
1 0 013 000000dd 00000000 0
0 2 010 00000000 ddccbbaa 0
1 2 020 a5a5a5a5 00000000 0
1 1 020 0000beef 00000000 0
0 2 020 00000000 a5a5beef 0
1 1 022 1234cafe 00000000 0
0 2 020 00000000 cafebeef 0
1 2 030 8001ff7f 00000000 0
0 0 030 00000000 0000007f 0
0 0 031 00000000 ffffffff 0
0 0 032 00000000 00000001 0
0 0 033 00000000 ffffff80 0
0 4 030 00000000 0000007f 0
0 4 031 00000000 000000ff 0
0 4 032 00000000 00000001 0
0 4 033 00000000 00000080 0
0 1 030 00000000 ffffff7f 0
0 1 032 00000000 ffff8001 0
0 5 030 00000000 0000ff7f 0
0 5 032 00000000 00008001 0
0 1 031 00000000 00000000 1
0 2 032 00000000 00000000 1
0 5 033 00000000 00000000 1
1 1 001 0000ffff 00000000 1
1 2 006 ffffffff 00000000 1
1 4 000 000000ff 00000000 1
1 5 000 0000ffff 00000000 1
0 3 000 00000000 00000000 1
1 7 000 00000000 00000000 1
0 6 004 00000000 00000000 1
1 1 023 00000000 00000000 1
0 2 000 00000000 12345678 0
0 2 004 00000000 deadbeef 0
0 2 020 00000000 cafebeef 0

// File: tests/tb_data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem_unit;

    import mem_pkg::*;

    localparam int addr_width = 11;
    localparam int resp_limit = 8;      // cycles to wait for any response.
    localparam int max_random = 16;
    localparam int reset_cycles = 8;

    typedef struct packed {
        logic                  is_store;
        logic [2:0]            f3;
        logic [addr_width-1:0] addr;
        logic [31:0]           wdata;
        logic [31:0]           exp_rdata;
        logic                  exp_fault;
    } vec_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  we;
    mem_funct3_e           funct3;
    logic [addr_width-1:0] addr;
    logic [31:0]           wdata;
    logic                  busy;
    logic                  rd_valid;
    logic [31:0]           rdata;
    logic                  fault;

    vec_t        vectors[$];
    bit          loaded;
    int          value_errors;
    int          other_errors;
    logic [31:0] model [0:15];     // words of the random region.
    bit          written [0:15];

    data_mem_unit #(.addr_width(addr_width)) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .funct3   (funct3),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .rd_valid (rd_valid),
        .rdata    (rdata),
        .fault    (fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] op;
        logic [31:0] f3;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] er;
        logic [31:0] ef;
        vec_t        v;
        fd = $fopen("tests/golden_vectors.txt", "r");
        assert (fd != 0) else begin
            other_errors++;
            $display("could not open the golden vector file tests/golden_vectors.txt");
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h", op, f3, a, wd, er, ef);
                    if (code == 6) begin
                        v.is_store  = op[0];
                        v.f3        = f3[2:0];
                        v.addr      = a[addr_width-1:0];
                        v.wdata     = wd;
                        v.exp_rdata = er;
                        v.exp_fault = ef[0];
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
        assert (vectors.size() > 0) else begin
            other_errors++;
            $display("the golden vector file holds no usable access lines");
        end
    endtask

    // starts and returns on a falling edge.
    task automatic run_access(input bit is_store, input logic [2:0] f3,
            input logic [addr_width-1:0] a, input logic [31:0] wd,
            input logic [31:0] exp_rdata, input bit exp_fault);
        int waited;
        int busy_cycles;
        req    = 1'b1;
        we     = is_store;
        funct3 = mem_funct3_e'(f3);
        addr   = a;
        wdata  = wd;
        @(negedge clk);
        req    = 1'b0;
        we     = 1'b0;
        waited = 1;
        if (exp_fault || !is_store) begin
            while (!rd_valid && !fault && waited < resp_limit) begin
                @(negedge clk);
                waited++;
            end
            assert (rd_valid || fault) else begin
                other_errors++;
                $display("no rd_valid or fault within %0d cycles of the access at 0x%03h",
                    resp_limit, a);
            end
            if (rd_valid || fault) begin
                check_value("response latency", waited, 1);
                check_value("fault", fault, exp_fault);
                check_value("rd_valid", rd_valid, !exp_fault);
                if (!exp_fault) begin
                    check_value("rdata", rdata, exp_rdata);
                end
            end
            check_value("busy", busy, 1'b0);
        end else begin
            busy_cycles = 0;
            check_value("fault", fault, 1'b0);
            check_value("rd_valid", rd_valid, 1'b0);
            while (busy && busy_cycles < resp_limit) begin
                busy_cycles++;
                @(negedge clk);
            end
            assert (!busy) else begin
                other_errors++;
                $display("busy stayed high after the store at 0x%03h", a);
            end
            check_value("busy cycles", busy_cycles, 1);
        end
    endtask

    // aligned word traffic in a region the golden vectors never touch.
    task automatic random_phase();
        int          n;
        logic [3:0]  idx;
        logic [31:0] d;
        logic [addr_width-1:0] a;
        n = 8 + ($urandom % (max_random - 7));
        for (int k = 0; k < n; k++) begin
            idx = $urandom % 16;
            a   = 11'h400 | {5'd0, idx, 2'b00};
            if (!written[idx] || ($urandom % 2) == 0) begin
                d = $urandom;
                run_access(1'b1, 3'b010, a, d, 32'h0, 1'b0);
                model[idx]   = d;
                written[idx] = 1'b1;
            end else begin
                run_access(1'b0, 3'b010, a, 32'h0, model[idx], 1'b0);
            end
        end
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = (vectors.size() + max_random) * 10 + reset_cycles + 4;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n  = 1'b0;
        req    = 1'b0;
        we     = 1'b0;
        funct3 = f3_byte;
        addr   = '0;
        wdata  = '0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 16; i++) begin
            written[i] = 1'b0;
        end
        void'($urandom(11176));
        load_vectors();
        loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 1'b0);  // idle before any request.
        check_value("rd_valid", rd_valid, 1'b0);
        check_value("fault", fault, 1'b0);
        foreach (vectors[i]) begin
            run_access(vectors[i].is_store, vectors[i].f3, vectors[i].addr,
                vectors[i].wdata, vectors[i].exp_rdata, vectors[i].exp_fault);
        end
        random_phase();
        repeat (2) @(negedge clk);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/data_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_unit #(
    parameter int addr_width = 11
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req,
    input  logic                           we,
    input  mem_pkg::mem_funct3_e           funct3,
    input  logic [addr_width-1:0]          addr,
    input  logic [mem_pkg::data_width-1:0] wdata,
    output logic                           busy,
    output logic                           rd_valid,
    output logic [mem_pkg::data_width-1:0] rdata,
    output logic                           fault
);

    import mem_pkg::*;

    localparam int word_addr_width = addr_width - off_width;

    logic [word_addr_width-1:0] ram_addr;
    logic                       ram_we;
    mem_funct3_e                acc_funct3;
    logic [off_width-1:0]       acc_off;
    logic [data_width-1:0]      old_word;
    logic [data_width-1:0]      new_word;
    logic [data_width-1:0]      wdata_q;  // store data held for the merge.

    always_ff @(posedge clk) begin
        if (req && !busy) begin
            wdata_q <= wdata;
        end
    end

    mem_sequencer #(.addr_width(addr_width)) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .we         (we),
        .funct3     (funct3),
        .addr       (addr),
        .busy       (busy),
        .rd_valid   (rd_valid),
        .fault      (fault),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .acc_funct3 (acc_funct3),
        .acc_off    (acc_off)
    );

    word_ram #(.addr_width(word_addr_width)) u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .d    (new_word),
        .q    (old_word)
    );

    store_merge u_merge (
        .old_word   (old_word),
        .store_data (wdata_q),
        .acc_funct3 (acc_funct3),
        .acc_off    (acc_off),
        .new_word   (new_word)
    );

    load_extend u_extend (
        .word       (old_word),
        .acc_funct3 (acc_funct3),
        .acc_off    (acc_off),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: verilog/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic [mem_pkg::data_width-1:0] word,
    input  mem_pkg::mem_funct3_e           acc_funct3,
    input  logic [mem_pkg::off_width-1:0]  acc_off,
    output logic [mem_pkg::data_width-1:0] rdata
);

    import mem_pkg::*;

    logic [data_width-1:0] shifted;  // addressed byte or half moved to bit 0.

    assign shifted = word >> {acc_off, 3'b000};

    always_comb begin
        case (acc_funct3)
            f3_byte: begin
                rdata = {{(data_width-8){shifted[7]}}, shifted[7:0]};
            end
            f3_half: begin
                rdata = {{(data_width-16){shifted[15]}}, shifted[15:0]};
            end
            f3_byte_u: begin
                rdata = {{(data_width-8){1'b0}}, shifted[7:0]};
            end
            f3_half_u: begin
                rdata = {{(data_width-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                rdata = word;  // word loads pass through.
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int data_width = 32;  // rv32 word.
    localparam int off_width  = 2;   // byte offset inside a word.

    // funct3 codes shared by loads and stores.
    typedef enum logic [2:0] {
        f3_byte   = 3'b000,
        f3_half   = 3'b001,
        f3_word   = 3'b010,
        f3_byte_u = 3'b100,
        f3_half_u = 3'b101
    } mem_funct3_e;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_store_read,
        st_store_write
    } seq_state_e;

endpackage

`default_nettype wire

// File: verilog/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer #(
    parameter int addr_width = 11
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      req,
    input  logic                                      we,
    input  mem_pkg::mem_funct3_e                      funct3,
    input  logic [addr_width-1:0]                     addr,
    output logic                                      busy,
    output logic                                      rd_valid,
    output logic                                      fault,
    output logic [addr_width-mem_pkg::off_width-1:0]  ram_addr,
    output logic                                      ram_we,
    output mem_pkg::mem_funct3_e                      acc_funct3,
    output logic [mem_pkg::off_width-1:0]             acc_off
);

    import mem_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    seq_state_e req_state;  // phase an incoming request starts in.

    logic                           accept;
    logic                           legal_f3;
    logic                           aligned;
    logic [addr_width-off_width-1:0] word_addr_q;

    assign accept = req && !busy;

    // funct3 legality and alignment of the incoming request.
    always_comb begin
        legal_f3 = 1'b0;
        aligned  = 1'b0;
        case (funct3)
            f3_byte: begin
                legal_f3 = 1'b1;
                aligned  = 1'b1;
            end
            f3_half: begin
                legal_f3 = 1'b1;
                aligned  = !addr[0];
            end
            f3_word: begin
                legal_f3 = 1'b1;
                aligned  = (addr[1:0] == 2'b00);
            end
            f3_byte_u: begin
                legal_f3 = !we;  // unsigned codes are loads only.
                aligned  = 1'b1;
            end
            f3_half_u: begin
                legal_f3 = !we;
                aligned  = !addr[0];
            end
            default: begin
                legal_f3 = 1'b0;
            end
        endcase
    end

    // the RAM read of a store is issued in the request cycle itself,
    // so the registered state goes straight on to the write phase.
    always_comb begin
        req_state = st_idle;
        if (accept && legal_f3 && aligned) begin
            req_state = we ? st_store_read : st_load;
        end
    end

    assign next_state = (req_state == st_store_read) ? st_store_write : req_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            fault <= 1'b0;
        end else begin
            state <= next_state;
            fault <= accept && !(legal_f3 && aligned);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_funct3  <= funct3;
            acc_off     <= addr[off_width-1:0];
            word_addr_q <= addr[addr_width-1:off_width];
        end
    end

    assign busy     = (state == st_store_write);
    assign ram_we   = (state == st_store_write);
    assign rd_valid = (state == st_load);
    assign ram_addr = busy ? word_addr_q : addr[addr_width-1:off_width];  // write back in place.

    a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
        else $error("req issued while busy");

    a_valid_fault: assert property (@(posedge clk) disable iff (!rst_n) !(rd_valid && fault))
        else $error("rd_valid and fault high together");

endmodule

`default_nettype wire

// File: verilog/store_merge.sv
`timescale 1ns/1ps
`default_nettype none

module store_merge (
    input  logic [mem_pkg::data_width-1:0] old_word,
    input  logic [mem_pkg::data_width-1:0] store_data,
    input  mem_pkg::mem_funct3_e           acc_funct3,
    input  logic [mem_pkg::off_width-1:0]  acc_off,
    output logic [mem_pkg::data_width-1:0] new_word
);

    import mem_pkg::*;

    localparam int lanes = data_width / 8;

    logic [lanes-1:0]      lane_en;    // byte lanes taken from store data.
    logic [data_width-1:0] lane_data;  // store data copied into every lane it may land in.

    // the low byte or halfword is replicated across the word, so the
    // lane enables alone pick the addressed position.
    always_comb begin
        case (acc_funct3)
            f3_byte: begin
                lane_en   = 4'b0001 << acc_off;
                lane_data = {4{store_data[7:0]}};
            end
            f3_half: begin
                lane_en   = 4'b0011 << acc_off;  // offset is 0 or 2 here.
                lane_data = {2{store_data[15:0]}};
            end
            f3_word: begin
                lane_en   = 4'b1111;
                lane_data = store_data;
            end
            default: begin
                lane_en   = 4'b0000;  // illegal code keeps the old word.
                lane_data = store_data;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            if (lane_en[i]) begin
                new_word[8*i +: 8] = lane_data[8*i +: 8];
            end else begin
                new_word[8*i +: 8] = old_word[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int addr_width = 9
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [addr_width-1:0]          addr,
    input  logic [mem_pkg::data_width-1:0] d,
    output logic [mem_pkg::data_width-1:0] q
);

    import mem_pkg::*;

    logic [data_width-1:0] mem [0:2**addr_width-1];

    // read before write, so q shows the old word on a write edge.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= d;
        end
        q <= mem[addr];
    end

    a_write_addr_known: assert property (@(posedge clk) we |-> !$isunknown(addr))
        else $error("word_ram write with unknown address");

endmodule

`default_nettype wire
